/* design/cnn_buf_pkg.sv */
package cnn_buf_pkg;

	// ------------------------------------------------------------------------
	// frame geometry of the layer 1 output map.
	// ------------------------------------------------------------------------

	// pixels per row.
	localparam int FMAP_WIDTH  = 30;
	// rows per frame.
	localparam int FMAP_HEIGHT = 30;
	// entries per frame, one per output pixel.
	localparam int FMAP_DEPTH  = FMAP_WIDTH * FMAP_HEIGHT;

	// ------------------------------------------------------------------------
	// widths.
	// ------------------------------------------------------------------------

	// one layer 1 result word.
	localparam int DATA_W  = 128;
	// flat sram address, covers 900 entries.
	localparam int ADDR_W  = 10;
	// row or column index, 0 to 29.
	localparam int COORD_W = 5;

	// row * 30 built as row * 32 - row * 2.
	localparam int ROW_SHL_HI = 5;
	localparam int ROW_SHL_LO = 1;

	typedef logic [DATA_W-1:0]  result_t;
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [ADDR_W-1:0]  sram_addr_t;

	// last raster position in a frame.
	localparam coord_t LAST_ROW = coord_t'(FMAP_HEIGHT - 1);
	localparam coord_t LAST_COL = coord_t'(FMAP_WIDTH - 1);

	// ------------------------------------------------------------------------
	// four-phase handshake states, shared by writer and reader.
	// ------------------------------------------------------------------------

	typedef enum logic [1:0]
	{
		// waiting for req.
		HS_IDLE,
		// sram access in flight, two cycles.
		HS_ACCESS,
		// ack high until req drops.
		HS_ACK
	} hs_state_e;

endpackage

/* design/result_port_if.sv */
`timescale 1ns/100ps
interface result_port_if
	import cnn_buf_pkg::*;
();

	// save group, driven by the writer.
	logic       save_enable;
	coord_t     save_row;
	coord_t     save_col;
	result_t    save_data;

	// read group, request from the reader.
	logic       read_enable;
	coord_t     read_row;
	coord_t     read_col;
	// registered word back from the sram.
	result_t    read_data;

	modport writer (output save_enable, save_row, save_col, save_data);

	modport reader (output read_enable, read_row, read_col, input read_data);

	// memory side, mirror of both.
	modport mem (
		input  save_enable, save_row, save_col, save_data,
		input  read_enable, read_row, read_col,
		output read_data
	);

endinterface

/* design/result_sram.sv */
`timescale 1ns/100ps
module result_sram
	import cnn_buf_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	result_port_if.mem    mem,
	input  sram_addr_t    save_addr,
	input  sram_addr_t    read_addr
);

	// ------------------------------------------------------------------------
	// storage, one word per output pixel.
	// ------------------------------------------------------------------------

	result_t ram [FMAP_DEPTH];

	// port a, write only.
	// word lands at the edge where save_enable is high.
	always_ff @(posedge clk)
	begin
		if (mem.save_enable)
		begin
			ram[save_addr] <= mem.save_data;
		end
	end

	// ------------------------------------------------------------------------
	// port b, read only.
	// ------------------------------------------------------------------------

	// registered output.
	// holds its last word while read_enable is low.
	// same-address collision with port a returns the old word.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mem.read_data <= '0;
		end
		else if (mem.read_enable)
		begin
			mem.read_data <= ram[read_addr];
		end
	end

endmodule

/* design/layer1_result_mem.sv */
`timescale 1ns/100ps
module layer1_result_mem
	import cnn_buf_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	result_port_if.mem    mem
);

	sram_addr_t save_addr;
	sram_addr_t read_addr;

	// flat address from row and column.
	// row * 30 + col, done as (row << 5) - (row << 1) + col.
	function automatic sram_addr_t flat_addr(coord_t row, coord_t col);
		sram_addr_t row_x32;
		sram_addr_t row_x2;
		row_x32 = sram_addr_t'(row) << ROW_SHL_HI;
		row_x2  = sram_addr_t'(row) << ROW_SHL_LO;
		return row_x32 - row_x2 + sram_addr_t'(col);
	endfunction

	// port a address.
	assign save_addr = flat_addr(mem.save_row, mem.save_col);
	// port b address.
	assign read_addr = flat_addr(mem.read_row, mem.read_col);

	// two-port array, a writes and b reads.
	result_sram u_sram (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem       (mem),
		.save_addr (save_addr),
		.read_addr (read_addr)
	);

endmodule

/* design/result_writer.sv */
`timescale 1ns/100ps
module result_writer
	import cnn_buf_pkg::*;
(
	input  logic            clk,
	input  logic            arst_n,
	input  logic            wr_req,
	input  result_t         wr_data,
	output logic            wr_ack,
	output logic            frame_done,
	result_port_if.writer   port
);

	hs_state_e state;
	// raster position of the next result.
	coord_t    row_cnt;
	coord_t    col_cnt;
	logic      accept;

	// new result taken in idle.
	assign accept = (state == HS_IDLE) && wr_req;

	// ------------------------------------------------------------------------
	// handshake fsm.
	// ------------------------------------------------------------------------

	// access spans two cycles.
	// first cycle writes, second one raises ack.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state            <= HS_IDLE;
			port.save_enable <= 1'b0;
			wr_ack           <= 1'b0;
		end
		else
		begin
			// write strobe is a single pulse.
			port.save_enable <= 1'b0;
			case (state)
				HS_IDLE:
				begin
					if (wr_req)
					begin
						state            <= HS_ACCESS;
						port.save_enable <= 1'b1;
					end
				end
				HS_ACCESS:
				begin
					// write done on the previous edge.
					if (!port.save_enable)
					begin
						state  <= HS_ACK;
						wr_ack <= 1'b1;
					end
				end
				HS_ACK:
				begin
					// stay here while req is held, no new access.
					if (!wr_req)
					begin
						state  <= HS_IDLE;
						wr_ack <= 1'b0;
					end
				end
				default:
				begin
					state <= HS_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// raster counters and frame flag.
	// ------------------------------------------------------------------------

	// column wraps at 29, row steps on column wrap.
	// both wrap to zero after pixel 899.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else if (accept)
		begin
			if (col_cnt == LAST_COL)
			begin
				col_cnt <= '0;
				row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + 1'b1;
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// set on the write of the last pixel.
	// cleared when the next frame starts.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_done <= 1'b0;
		end
		else if (accept)
		begin
			frame_done <= 1'b0;
		end
		else if (port.save_enable && port.save_row == LAST_ROW && port.save_col == LAST_COL)
		begin
			frame_done <= 1'b1;
		end
	end

	// payload for the save bus, loaded at acceptance.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			port.save_row  <= row_cnt;
			port.save_col  <= col_cnt;
			port.save_data <= wr_data;
		end
	end

endmodule

/* design/result_reader.sv */
`timescale 1ns/100ps
module result_reader
	import cnn_buf_pkg::*;
(
	input  logic            clk,
	input  logic            arst_n,
	input  logic            rd_req,
	input  coord_t          rd_row,
	input  coord_t          rd_col,
	output logic            rd_ack,
	output result_t         rd_data,
	result_port_if.reader   port
);

	hs_state_e state;
	logic      accept;

	// fetch taken in idle.
	assign accept = (state == HS_IDLE) && rd_req;

	// ------------------------------------------------------------------------
	// handshake fsm.
	// ------------------------------------------------------------------------

	// edge n   accept, read_enable up.
	// edge n+1 sram registers the word.
	// edge n+2 word into rd_data, ack up.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state            <= HS_IDLE;
			port.read_enable <= 1'b0;
			rd_ack           <= 1'b0;
			rd_data          <= '0;
		end
		else
		begin
			// read strobe is a single pulse.
			port.read_enable <= 1'b0;
			case (state)
				HS_IDLE:
				begin
					if (rd_req)
					begin
						state            <= HS_ACCESS;
						port.read_enable <= 1'b1;
					end
				end
				HS_ACCESS:
				begin
					// sram output valid once the strobe is gone.
					if (!port.read_enable)
					begin
						state   <= HS_ACK;
						rd_ack  <= 1'b1;
						rd_data <= port.read_data;
					end
				end
				HS_ACK:
				begin
					// held req keeps us here, rd_data untouched.
					if (!rd_req)
					begin
						state  <= HS_IDLE;
						rd_ack <= 1'b0;
					end
				end
				default:
				begin
					state <= HS_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// coordinate latch.
	// ------------------------------------------------------------------------

	// requester holds them anyway, latched so the sram sees a clean copy.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			port.read_row <= rd_row;
			port.read_col <= rd_col;
		end
	end

endmodule

/* design/layer1_buffer_top.sv */
`timescale 1ns/100ps
module layer1_buffer_top
	import cnn_buf_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	// write side, from layer 1.
	input  logic    wr_req,
	input  result_t wr_data,
	output logic    wr_ack,
	output logic    frame_done,
	// read side, from layer 2.
	input  logic    rd_req,
	input  coord_t  rd_row,
	input  coord_t  rd_col,
	output logic    rd_ack,
	output result_t rd_data
);

	// internal save and read buses.
	result_port_if u_port ();

	// raster writer, four-phase on wr_req.
	result_writer u_writer (
		.clk        (clk),
		.arst_n     (arst_n),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.wr_ack     (wr_ack),
		.frame_done (frame_done),
		.port       (u_port.writer)
	);

	// random pixel reader, four-phase on rd_req.
	result_reader u_reader (
		.clk     (clk),
		.arst_n  (arst_n),
		.rd_req  (rd_req),
		.rd_row  (rd_row),
		.rd_col  (rd_col),
		.rd_ack  (rd_ack),
		.rd_data (rd_data),
		.port    (u_port.reader)
	);

	// address mapping plus sram.
	layer1_result_mem u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.mem    (u_port.mem)
	);

endmodule

/* sim/tb_layer1_buffer.sv */
`timescale 1ns/100ps
module tb_layer1_buffer
	import cnn_buf_pkg::*;
();

	logic    clk;
	logic    arst_n;
	logic    wr_req;
	result_t wr_data;
	logic    wr_ack;
	logic    frame_done;
	logic    rd_req;
	coord_t  rd_row;
	coord_t  rd_col;
	logic    rd_ack;
	result_t rd_data;

	// reference frame, flat index row * 30 + col.
	result_t model [FMAP_DEPTH];
	// raster pixels sent so far, all frames.
	int      wr_count;
	// expected values, loaded with each request.
	result_t exp_rd_data;
	logic    exp_frame_done;
	int      errors;
	logic    timed_out;
	// edges allowed per handshake phase.
	int      wait_limit = 64;

	layer1_buffer_top DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.wr_ack     (wr_ack),
		.frame_done (frame_done),
		.rd_req     (rd_req),
		.rd_row     (rd_row),
		.rd_col     (rd_col),
		.rd_ack     (rd_ack),
		.rd_data    (rd_data)
	);

	// 40 ns clock.
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// checks, all on sampled values at the rising edge.
	// ------------------------------------------------------------------------

	// outputs in reset and one edge past release.
	reset_values: assert property (@(posedge clk) $past(!arst_n) |->
		!wr_ack && !rd_ack && !frame_done && rd_data == '0)
		else log_error($sformatf("ERROR: wr_ack = %h rd_ack = %h frame_done = %h rd_data = %h",
			$sampled(wr_ack), $sampled(rd_ack), $sampled(frame_done), $sampled(rd_data)));

	// accept at n, ack driven at n+2, seen as a rise at n+3.
	wr_ack_timing: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(wr_ack) |-> $past(wr_req, 3) && !$past(wr_req, 4))
		else log_error("wr_ack did not rise two edges after wr_req was taken");
	// held while req is up, dropped one edge after req falls.
	wr_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		$past(wr_ack) |-> wr_ack == $past(wr_req))
		else log_error($sformatf("ERROR: wr_ack = %h, expected %h",
			$sampled(wr_ack), !$sampled(wr_ack)));
	// no write strobe during the ack phase.
	wr_no_access: assert property (@(posedge clk) disable iff (!arst_n)
		wr_ack |-> !DUT.u_port.save_enable)
		else log_error("ERROR: save_enable = 1 while wr_ack is high, expected 0");
	// low before the 900th ack, high after it until the next frame.
	frame_done_value: assert property (@(posedge clk) disable iff (!arst_n)
		(wr_ack || !wr_req) |-> frame_done == exp_frame_done)
		else log_error($sformatf("ERROR: frame_done = %h, expected %h",
			$sampled(frame_done), $sampled(exp_frame_done)));
	// low on the edge after a write is taken.
	frame_done_clear: assert property (@(posedge clk) disable iff (!arst_n)
		$past(wr_req) && !$past(wr_req, 2) |-> !frame_done)
		else log_error($sformatf("ERROR: frame_done = %h, expected 0 after acceptance",
			$sampled(frame_done)));

	rd_ack_timing: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(rd_ack) |-> $past(rd_req, 3) && !$past(rd_req, 4))
		else log_error("rd_ack did not rise two edges after rd_req was taken");
	rd_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		$past(rd_ack) |-> rd_ack == $past(rd_req))
		else log_error($sformatf("ERROR: rd_ack = %h, expected %h",
			$sampled(rd_ack), !$sampled(rd_ack)));
	rd_no_access: assert property (@(posedge clk) disable iff (!arst_n)
		rd_ack |-> !DUT.u_port.read_enable)
		else log_error("ERROR: read_enable = 1 while rd_ack is high, expected 0");
	// fetched word against the model.
	rd_data_value: assert property (@(posedge clk) disable iff (!arst_n)
		rd_ack |-> rd_data == exp_rd_data)
		else log_error($sformatf("ERROR: rd_data = %h, expected %h",
			$sampled(rd_data), $sampled(exp_rd_data)));

	// ------------------------------------------------------------------------
	// helpers.
	// ------------------------------------------------------------------------

	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic finish_run();
		$display("errors: %0d, timeouts: %0d", errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		timed_out = 1'b1;
		finish_run();
	endtask

	// polls one ack, one edge at a time.
	task automatic wait_ack(input logic on_write, input logic level, input string what);
		int   cnt;
		logic ack;
		cnt = 0;
		do
		begin
			@(posedge clk);
			cnt++;
			ack = on_write ? wr_ack : rd_ack;
		end
		while (ack != level && cnt < wait_limit);
		if (ack != level)
			abort_run({"timeout while waiting for ", what});
	endtask

	function automatic result_t random_result();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// one four-phase write, req held for hold extra edges.
	task automatic send_result(input result_t data, input int hold);
		@(posedge clk);
		wr_data        <= data;
		wr_req         <= 1'b1;
		exp_frame_done <= (wr_count % FMAP_DEPTH) == FMAP_DEPTH - 1;
		model[sram_addr_t'(wr_count % FMAP_DEPTH)] = data;
		wr_count++;
		wait_ack(1'b1, 1'b1, "wr_ack to rise");
		repeat (hold) @(posedge clk);
		wr_req <= 1'b0;
		wait_ack(1'b1, 1'b0, "wr_ack to fall");
	endtask

	// one four-phase fetch.
	task automatic fetch_pixel(input coord_t row, input coord_t col, input int hold);
		@(posedge clk);
		rd_row      <= row;
		rd_col      <= col;
		rd_req      <= 1'b1;
		exp_rd_data <= model[sram_addr_t'(int'(row) * FMAP_WIDTH + int'(col))];
		wait_ack(1'b0, 1'b1, "rd_ack to rise");
		repeat (hold) @(posedge clk);
		rd_req <= 1'b0;
		wait_ack(1'b0, 1'b0, "rd_ack to fall");
	endtask

	// ------------------------------------------------------------------------
	// stimulus.
	// ------------------------------------------------------------------------

	initial
	begin
		void'($urandom(32'hf0efd860));
		errors         = 0;
		timed_out      = 1'b0;
		wr_count       = 0;
		exp_rd_data    = '0;
		exp_frame_done = 1'b0;
		arst_n         = 1'b0;
		wr_req         = 1'b0;
		wr_data        = '0;
		rd_req         = 1'b0;
		rd_row         = '0;
		rd_col         = '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		// full first frame.
		for (int i = 0; i < FMAP_DEPTH; i++)
			send_result(random_result(), 0);

		// corners, then random pixels.
		fetch_pixel(coord_t'(0), coord_t'(0), 0);
		fetch_pixel(coord_t'(0), LAST_COL, 0);
		fetch_pixel(LAST_ROW, coord_t'(0), 0);
		fetch_pixel(LAST_ROW, LAST_COL, 0);
		for (int i = 0; i < 60; i++)
			fetch_pixel(coord_t'($urandom_range(FMAP_HEIGHT - 1)),
				coord_t'($urandom_range(FMAP_WIDTH - 1)), 0);

		// second frame, first write held under back-pressure.
		send_result(random_result(), 6);
		for (int i = 1; i < 40; i++)
			send_result(random_result(), 0);

		// new words up to 39, old ones from 40.
		fetch_pixel(coord_t'(0), coord_t'(0), 6);
		for (int p = 1; p < 46; p++)
			fetch_pixel(coord_t'(p / FMAP_WIDTH), coord_t'(p % FMAP_WIDTH), 0);

		finish_run();
	end

endmodule

/* sim.f */
design/cnn_buf_pkg.sv
design/result_port_if.sv
design/result_sram.sv
design/layer1_result_mem.sv
design/result_writer.sv
design/result_reader.sv
design/layer1_buffer_top.sv
sim/tb_layer1_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the layer 1 buffer testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f sim.f --top-module tb_layer1_buffer \
	-o tb_layer1_buffer > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_layer1_buffer > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1
